//--- pong_board.f
source/game_pkg.sv
source/link_pkg.sv
source/ball_link_if.sv
source/frame_deframer.sv
source/ball_controller.sv
source/frame_framer.sv
source/pong_board.sv
test/pong_board_sva.sv
test/pong_board_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module pong_board_tb -Mdir obj_dir -f pong_board.f &&
./obj_dir/Vpong_board_tb ||
{ echo "simulation failed"; exit 1; }

//--- test/pong_board_tb.sv
`timescale 1ns/100ps

module pong_board_tb;

    // one rally per row, reply is the frame kind expected back (3 means dropped)
    typedef struct packed {
        logic [1:0] kind;
        logic       speed_sel;
        logic [1:0] gravity;
        logic [9:0] y;
        logic [7:0] vy;
        logic       win;
        logic       upscale;
        logic       hit;
        logic [4:0] hit_step;
        logic [9:0] speed;
        logic [1:0] reply;
    } rally_t;

    localparam int n_rallies = 8;
    localparam int max_wait  = 4000;

    localparam rally_t rallies [n_rallies] = '{
        //  kind  spd   grav  y        vy      win   up    hit   step   speed   reply
        '{2'd0, 1'b0, 2'd1, 10'd100, 8'sd5,  1'b0, 1'b0, 1'b0, 5'd0,  10'd0,  2'd1},
        '{2'd0, 1'b1, 2'd2, 10'd30,  -8'sd7, 1'b0, 1'b0, 1'b1, 5'd3,  10'd2,  2'd0},
        '{2'd2, 1'b0, 2'd0, 10'd0,   8'sd0,  1'b1, 1'b0, 1'b0, 5'd0,  10'd0,  2'd2},
        '{2'd0, 1'b0, 2'd0, 10'd200, 8'sd12, 1'b0, 1'b0, 1'b1, 5'd5,  10'd3,  2'd0},
        '{2'd3, 1'b0, 2'd1, 10'd77,  8'sd1,  1'b0, 1'b0, 1'b0, 5'd0,  10'd0,  2'd3},
        '{2'd0, 1'b1, 2'd3, 10'd400, 8'sd9,  1'b0, 1'b1, 1'b1, 5'd10, 10'd0,  2'd0},
        '{2'd0, 1'b0, 2'd0, 10'd450, -8'sd3, 1'b0, 1'b1, 1'b0, 5'd0,  10'd0,  2'd1},
        '{2'd0, 1'b0, 2'd2, 10'd5,   8'sd2,  1'b0, 1'b0, 1'b1, 5'd0,  10'd20, 2'd0}
    };

    logic                  clk_25MHZ = 1'b0;
    logic                  reset;
    logic                  upscale;
    logic                  collision_detected;
    logic [9:0]            estimated_speed;
    logic [7:0]            rx_byte;
    logic                  rx_valid;
    logic                  rx_ready;
    logic [7:0]            tx_byte;
    logic                  tx_valid;
    logic                  tx_ready;
    game_pkg::ball_coord_t ball_x;
    game_pkg::ball_coord_t ball_y;
    logic                  moving_right;
    logic                  game_over;
    logic [7:0]            score;
    logic                  you_win;
    logic                  is_idle;

    logic [31:0] lfsr = 32'h31df_cabf;
    int          go_count = 0;

    pong_board u_pong_board (
        .clk_25MHZ          (clk_25MHZ),
        .reset              (reset),
        .upscale            (upscale),
        .collision_detected (collision_detected),
        .estimated_speed    (estimated_speed),
        .rx_byte            (rx_byte),
        .rx_valid           (rx_valid),
        .rx_ready           (rx_ready),
        .tx_byte            (tx_byte),
        .tx_valid           (tx_valid),
        .tx_ready           (tx_ready),
        .ball_x             (ball_x),
        .ball_y             (ball_y),
        .moving_right       (moving_right),
        .game_over          (game_over),
        .score              (score),
        .you_win            (you_win),
        .is_idle            (is_idle)
    );

    always #20 clk_25MHZ = ~clk_25MHZ;

    always @(negedge clk_25MHZ) begin
        if (!reset && game_over) begin
            go_count++;
        end
    end

    // galois lfsr, one step for every bit handed out
    function automatic logic [3:0] random_bits(input int count);
        logic [3:0] bits;
        int         i;
        bits = 4'd0;
        for (i = 0; i < count; i++) begin
            bits = {bits[2:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return bits;
    endfunction

    task automatic end_with_failure();
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at time %0t: %s is %0h, expected %0h", $time, what, got, exp);
            end_with_failure();
        end
    endtask

    task automatic count_wait(inout int n, input string what);
        n++;
        if (n > max_wait) begin
            $display("Timeout at time %0t: %s never happened", $time, what);
            end_with_failure();
        end
    endtask

    // byte 0 first, same layout the board uses on its link
    function automatic logic [23:0] build_frame(input rally_t e);
        logic [7:0] b1;
        b1 = (e.kind == 2'd2) ? {7'd0, e.win} : e.y[7:0];
        return {e.vy, b1, 1'b0, e.y[9:8], e.speed_sel, e.gravity, e.kind};
    endfunction

    // reference ball flight: steps out to the paddle and back, or out to the far edge
    function automatic logic [23:0] predict_frame(input rally_t e);
        int         y;
        int         vy;
        int         g;
        int         vg;
        int         ys;
        int         y_max;
        int         n_steps;
        int         s;
        logic [9:0] y_out;
        logic [1:0] kind_out;
        y     = int'(e.y);
        vy    = int'($signed(e.vy));
        g     = int'(e.gravity);
        y_max = e.upscale ? int'(game_pkg::y_max_large) : int'(game_pkg::y_max_small);
        if (e.hit) begin
            n_steps  = 2 * int'(e.hit_step) + 2;  // k steps out, k + 2 steps back to x = 0
            kind_out = 2'd0;
        end else begin
            n_steps  = ((e.upscale ? 620 : 300) - 20) / 10;
            kind_out = 2'd1;
        end
        for (s = 0; s < n_steps; s++) begin
            vg = (g == 3) ? vy + 1 : vy;
            g  = (g == 3) ? 0 : g + 1;
            ys = y + vy;
            if (ys >= y_max) begin
                y  = y_max;
                vy = -vg;
            end else if (ys <= 0) begin
                y  = 0;
                vy = -vg;
            end else begin
                y  = ys;
                vy = vg;
            end
        end
        y_out = 10'(y);
        return {8'(vy), y_out[7:0], 1'b0, y_out[9:8], 1'b1, 2'(g), kind_out};
    endfunction

    task automatic send_byte(input logic [7:0] b);
        int gap;
        int n;
        gap = int'(random_bits(2));  // idle cycles before the byte
        repeat (gap) @(posedge clk_25MHZ);
        @(posedge clk_25MHZ);
        rx_byte  <= b;
        rx_valid <= 1'b1;
        n = 0;
        @(negedge clk_25MHZ);
        while (!rx_ready) begin
            count_wait(n, "rx_ready for an incoming byte");
            @(negedge clk_25MHZ);
        end
        @(posedge clk_25MHZ);
        rx_valid <= 1'b0;
    endtask

    task automatic receive_byte(output logic [7:0] b);
        logic [3:0] bits;
        logic       done;
        int         n;
        done = 1'b0;
        n    = 0;
        while (!done) begin
            @(posedge clk_25MHZ);
            bits = random_bits(2);
            tx_ready <= (bits[1:0] != 2'd0);  // stall about one cycle in four
            @(negedge clk_25MHZ);
            if (tx_valid && tx_ready) begin
                b    = tx_byte;
                done = 1'b1;
            end else begin
                count_wait(n, "an outgoing byte on tx");
            end
        end
        @(posedge clk_25MHZ);
        tx_ready <= 1'b0;
    endtask

    task automatic hit_paddle(input int k);
        logic [9:0] target;
        int         n;
        target = 10'(int'(game_pkg::entry_x) + int'(game_pkg::x_step) * k);
        n = 0;
        @(negedge clk_25MHZ);
        while (!(moving_right && ball_x == target)) begin
            count_wait(n, "ball reaching the paddle");
            @(negedge clk_25MHZ);
        end
        @(posedge clk_25MHZ);
        collision_detected <= 1'b1;
        n = 0;
        @(negedge clk_25MHZ);
        while (moving_right) begin
            count_wait(n, "ball turning left after the hit");
            @(negedge clk_25MHZ);
        end
        @(posedge clk_25MHZ);
        collision_detected <= 1'b0;
    endtask

    initial begin
        rally_t     e;
        logic [23:0] frame;
        logic [23:0] got;
        logic [7:0]  got_byte;
        logic [7:0]  exp_score;
        logic        exp_win;
        int          i;
        int          b;
        int          n;
        int          go_before;

        reset              <= 1'b1;
        upscale            <= 1'b0;
        collision_detected <= 1'b0;
        estimated_speed    <= 10'd0;
        rx_byte            <= 8'd0;
        rx_valid           <= 1'b0;
        tx_ready           <= 1'b0;
        exp_score = 8'd0;
        exp_win   = 1'b0;

        repeat (16) @(posedge clk_25MHZ);
        reset <= 1'b0;
        @(negedge clk_25MHZ);
        check_value("ball_x after reset", 32'(ball_x), 32'd10);
        check_value("ball_y after reset", 32'(ball_y), 32'd80);
        check_value("score after reset", 32'(score), 32'd0);
        check_value("rx_ready after reset", 32'(rx_ready), 32'd1);
        check_value("tx_valid after reset", 32'(tx_valid), 32'd0);
        check_value("is_idle after reset", 32'(is_idle), 32'd1);

        for (i = 0; i < n_rallies; i++) begin
            e = rallies[i];
            @(posedge clk_25MHZ);
            upscale         <= e.upscale;
            estimated_speed <= e.speed;
            go_before = go_count;
            frame = build_frame(e);
            for (b = 0; b < 3; b++) begin
                send_byte(frame[8*b +: 8]);
            end

            if (e.reply == 2'd0 || e.reply == 2'd1) begin
                if (e.hit) begin
                    hit_paddle(int'(e.hit_step));
                end
                for (b = 0; b < 3; b++) begin
                    receive_byte(got_byte);
                    got[8*b +: 8] = got_byte;
                end
                @(negedge clk_25MHZ);
                check_value($sformatf("frame sent in rally %0d", i), 32'(got),
                            32'(predict_frame(e)));
                if (e.reply == 2'd0) begin
                    exp_score = exp_score + 8'd1;
                end
                check_value("game_over pulses", 32'(go_count - go_before),
                            (e.reply == 2'd1) ? 32'd1 : 32'd0);
            end else if (e.reply == 2'd2) begin
                n = 0;
                @(negedge clk_25MHZ);
                while (you_win !== 1'b1) begin
                    count_wait(n, "you_win after a win frame");
                    @(negedge clk_25MHZ);
                end
                exp_win = 1'b1;
            end else begin
                @(negedge clk_25MHZ);  // a kept frame would hold rx_ready low here
                check_value("rx_ready after an unknown frame", 32'(rx_ready), 32'd1);
                check_value("moving_right after an unknown frame", 32'(moving_right), 32'd0);
            end

            check_value("score", 32'(score), 32'(exp_score));
            check_value("you_win", 32'(you_win), 32'(exp_win));
            check_value("is_idle", 32'(is_idle), 32'd1);
        end

        $display("No errors");
        $finish;
    end

endmodule

//--- test/pong_board_sva.sv
`timescale 1ns/100ps

module pong_board_sva (
    input logic       clk_25MHZ,
    input logic       reset,
    input logic       upscale,
    input logic [7:0] tx_byte,
    input logic       tx_valid,
    input logic       tx_ready,
    input logic       rec_valid,
    input logic       rec_ready,
    input logic       game_over,
    input logic       is_idle,
    input logic [9:0] ball_y
);

    logic [9:0] y_max;
    logic [1:0] bytes_left;  // bytes of the latest record not yet sent on tx

    assign y_max = upscale ? game_pkg::y_max_large : game_pkg::y_max_small;

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            bytes_left <= 2'd0;
        end else if (rec_valid && rec_ready) begin
            bytes_left <= 2'(link_pkg::frame_bytes);
        end else if (tx_valid && tx_ready && bytes_left != 2'd0) begin
            bytes_left <= bytes_left - 2'd1;
        end
    end

    tx_stall_stable: assert property (@(posedge clk_25MHZ) disable iff (reset)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_byte))
        else $error("tx byte changed while the link was stalled");

    // every byte of a frame has left before the next record is taken
    no_record_mid_frame: assert property (@(posedge clk_25MHZ) disable iff (reset)
        rec_valid && rec_ready |-> bytes_left == 2'd0)
        else $error("framer took a new record in the middle of a frame");

    tx_byte_in_frame: assert property (@(posedge clk_25MHZ) disable iff (reset)
        tx_valid |-> bytes_left != 2'd0)
        else $error("framer sent more bytes than one frame holds");

    game_over_pulse: assert property (@(posedge clk_25MHZ) disable iff (reset)
        game_over |=> !game_over)
        else $error("game_over stayed high for more than one cycle");

    ball_y_in_screen: assert property (@(posedge clk_25MHZ) disable iff (reset)
        !is_idle |-> ball_y <= y_max)
        else $error("ball_y went below the bottom of the screen");

endmodule

bind pong_board pong_board_sva u_pong_board_sva (
    .clk_25MHZ (clk_25MHZ),
    .reset     (reset),
    .upscale   (upscale),
    .tx_byte   (tx_byte),
    .tx_valid  (tx_valid),
    .tx_ready  (tx_ready),
    .rec_valid (tx_link.valid),
    .rec_ready (tx_link.ready),
    .game_over (game_over),
    .is_idle   (is_idle),
    .ball_y    (ball_y)
);

//--- source/pong_board.sv
`timescale 1ns/100ps

module pong_board (
    input  logic                  clk_25MHZ,
    input  logic                  reset,
    input  logic                  upscale,
    input  logic                  collision_detected,
    input  logic [9:0]            estimated_speed,
    input  logic [7:0]            rx_byte,
    input  logic                  rx_valid,
    output logic                  rx_ready,
    output logic [7:0]            tx_byte,
    output logic                  tx_valid,
    input  logic                  tx_ready,
    output game_pkg::ball_coord_t ball_x,
    output game_pkg::ball_coord_t ball_y,
    output logic                  moving_right,
    output logic                  game_over,
    output logic [7:0]            score,
    output logic                  you_win,
    output logic                  is_idle
);

    ball_link_if rx_link ();  // deframer to controller
    ball_link_if tx_link ();  // controller to framer

    frame_deframer u_frame_deframer (
        .clk_25MHZ (clk_25MHZ),
        .reset     (reset),
        .rx_byte   (rx_byte),
        .rx_valid  (rx_valid),
        .rx_ready  (rx_ready),
        .rec       (rx_link.sender)
    );

    ball_controller u_ball_controller (
        .clk_25MHZ          (clk_25MHZ),
        .reset              (reset),
        .upscale            (upscale),
        .collision_detected (collision_detected),
        .estimated_speed    (estimated_speed),
        .rx                 (rx_link.receiver),
        .tx                 (tx_link.sender),
        .ball_x             (ball_x),
        .ball_y             (ball_y),
        .moving_right       (moving_right),
        .game_over          (game_over),
        .score              (score),
        .you_win            (you_win),
        .is_idle            (is_idle)
    );

    frame_framer u_frame_framer (
        .clk_25MHZ (clk_25MHZ),
        .reset     (reset),
        .rec       (tx_link.receiver),
        .tx_byte   (tx_byte),
        .tx_valid  (tx_valid),
        .tx_ready  (tx_ready)
    );

endmodule

//--- source/frame_framer.sv
`timescale 1ns/100ps

module frame_framer (
    input  logic          clk_25MHZ,
    input  logic          reset,
    ball_link_if.receiver rec,
    output logic [7:0]    tx_byte,
    output logic          tx_valid,
    input  logic          tx_ready
);

    link_pkg::frame_t store;
    logic [1:0]       byte_cnt;
    logic             busy;
    logic             accept;
    logic             byte_done;

    assign rec.ready = !busy;  // closed until the last byte has left
    assign accept    = rec.valid && rec.ready;
    assign byte_done = tx_valid && tx_ready;

    assign tx_valid = busy;
    assign tx_byte  = store[0];

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            busy     <= 1'b0;
            byte_cnt <= 2'd0;
        end else begin
            if (accept) begin
                busy     <= 1'b1;
                byte_cnt <= 2'd0;
            end else if (byte_done) begin
                if (byte_cnt == 2'(link_pkg::frame_bytes - 1)) begin
                    busy <= 1'b0;
                end else begin
                    byte_cnt <= byte_cnt + 2'd1;
                end
            end
        end
    end

    always_ff @(posedge clk_25MHZ) begin
        if (accept) begin
            store <= link_pkg::pack_frame(rec.data);
        end else if (byte_done) begin
            store <= {8'h00, store[2:1]};  // next byte moves down to the output slot
        end
    end

endmodule

//--- source/ball_controller.sv
`timescale 1ns/100ps

module ball_controller (
    input  logic                 clk_25MHZ,
    input  logic                 reset,
    input  logic                 upscale,
    input  logic                 collision_detected,
    input  logic [9:0]           estimated_speed,
    ball_link_if.receiver        rx,
    ball_link_if.sender          tx,
    output game_pkg::ball_coord_t ball_x,
    output game_pkg::ball_coord_t ball_y,
    output logic                 moving_right,
    output logic                 game_over,
    output logic [7:0]           score,
    output logic                 you_win,
    output logic                 is_idle
);

    game_pkg::ctrl_state_t  state, state_next;
    game_pkg::ball_coord_t  ball_x_next, ball_y_next;
    game_pkg::ball_vel_t    ball_vy, ball_vy_next;
    logic [1:0]             grav_cnt, grav_cnt_next;
    game_pkg::step_period_t period, period_next;
    game_pkg::step_period_t step_cnt, step_cnt_next;
    logic [7:0]             score_next;
    logic                   game_over_next;
    logic                   you_win_next;

    game_pkg::ball_coord_t  y_max;
    game_pkg::ball_coord_t  right_limit;
    logic [9:0]             safe_speed;
    game_pkg::step_period_t ret_period;
    logic                   rx_take;
    logic                   step_now;

    game_pkg::ball_coord_t  x_step_val;
    game_pkg::ball_coord_t  y_step_val;
    game_pkg::ball_vel_t    vy_grav;
    game_pkg::ball_vel_t    vy_step_val;
    logic [1:0]             grav_step_val;
    logic signed [11:0]     y_sum;

    assign y_max       = upscale ? game_pkg::y_max_large : game_pkg::y_max_small;
    assign right_limit = upscale ? game_pkg::right_limit_large : game_pkg::right_limit_small;

    // a faster paddle swing gives a shorter step period on the way back
    assign safe_speed = (estimated_speed == 10'd0) ? 10'd1 : estimated_speed;
    assign ret_period = game_pkg::step_period_t'(game_pkg::return_base / safe_speed);

    assign rx_take  = rx.valid && rx.ready;
    assign step_now = ({1'b0, step_cnt} + 5'd1) >= {1'b0, period};

    assign rx.ready     = (state == game_pkg::IDLE) || (state == game_pkg::AWAIT_RESULT);
    assign is_idle      = rx.ready;
    assign moving_right = (state == game_pkg::RUN_RIGHT);

    // one motion step, y uses the velocity from before gravity is applied
    always_comb begin
        if (grav_cnt == game_pkg::gravity_wrap) begin
            vy_grav       = ball_vy + 10'sd1;
            grav_step_val = 2'd0;
        end else begin
            vy_grav       = ball_vy;
            grav_step_val = grav_cnt + 2'd1;
        end

        y_sum = $signed({2'b00, ball_y}) + $signed({{2{ball_vy[9]}}, ball_vy});

        if (y_sum >= $signed({2'b00, y_max})) begin
            y_step_val  = y_max;
            vy_step_val = -vy_grav;
        end else if (y_sum <= 12'sd0) begin
            y_step_val  = 10'd0;
            vy_step_val = -vy_grav;
        end else begin
            y_step_val  = y_sum[9:0];
            vy_step_val = vy_grav;
        end

        if (moving_right) begin
            x_step_val = ball_x + game_pkg::x_step;
        end else if (ball_x > game_pkg::x_step) begin
            x_step_val = ball_x - game_pkg::x_step;
        end else begin
            x_step_val = 10'd0;
        end
    end

    always_comb begin
        state_next     = state;
        ball_x_next    = ball_x;
        ball_y_next    = ball_y;
        ball_vy_next   = ball_vy;
        grav_cnt_next  = grav_cnt;
        period_next    = period;
        step_cnt_next  = step_cnt;
        score_next     = score;
        game_over_next = 1'b0;
        you_win_next   = you_win;

        case (state)
            game_pkg::IDLE, game_pkg::AWAIT_RESULT: begin
                if (rx_take) begin
                    state_next = game_pkg::IDLE;
                    if (rx.data.kind == link_pkg::kind_ball) begin
                        state_next    = game_pkg::RUN_RIGHT;
                        ball_x_next   = game_pkg::entry_x;
                        ball_y_next   = rx.data.y;
                        ball_vy_next  = {{2{rx.data.vy[7]}}, rx.data.vy};
                        grav_cnt_next = rx.data.gravity;
                        period_next   = rx.data.speed_sel ? game_pkg::step_cycles_slow
                                                          : game_pkg::step_cycles_fast;
                        step_cnt_next = 4'd0;
                    end else if (rx.data.kind == link_pkg::kind_win) begin
                        you_win_next = you_win || rx.data.win;
                    end
                end
            end

            game_pkg::RUN_RIGHT: begin
                if (collision_detected) begin
                    state_next    = game_pkg::RUN_LEFT;
                    period_next   = ret_period;
                    step_cnt_next = 4'd0;
                end else if (ball_x >= right_limit) begin
                    state_next = game_pkg::SEND_LOSE;  // the player missed
                end else if (step_now) begin
                    ball_x_next   = x_step_val;
                    ball_y_next   = y_step_val;
                    ball_vy_next  = vy_step_val;
                    grav_cnt_next = grav_step_val;
                    step_cnt_next = 4'd0;
                end else begin
                    step_cnt_next = step_cnt + 4'd1;
                end
            end

            game_pkg::RUN_LEFT: begin
                if (ball_x == 10'd0) begin
                    state_next = game_pkg::SEND_BALL;  // ball crosses to the opponent
                    score_next = score + 8'd1;
                end else if (step_now) begin
                    ball_x_next   = x_step_val;
                    ball_y_next   = y_step_val;
                    ball_vy_next  = vy_step_val;
                    grav_cnt_next = grav_step_val;
                    step_cnt_next = 4'd0;
                end else begin
                    step_cnt_next = step_cnt + 4'd1;
                end
            end

            game_pkg::SEND_LOSE: begin
                if (tx.ready) begin
                    state_next     = game_pkg::IDLE;
                    game_over_next = 1'b1;
                end
            end

            game_pkg::SEND_BALL: begin
                if (tx.ready) begin
                    state_next = game_pkg::AWAIT_RESULT;
                end
            end

            default: begin
                state_next = game_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            state     <= game_pkg::IDLE;
            ball_x    <= game_pkg::reset_x;
            ball_y    <= game_pkg::reset_y;
            ball_vy   <= 10'sd0;
            grav_cnt  <= 2'd0;
            period    <= game_pkg::step_cycles_slow;
            step_cnt  <= 4'd0;
            score     <= 8'd0;
            game_over <= 1'b0;
            you_win   <= 1'b0;
        end else begin
            state     <= state_next;
            ball_x    <= ball_x_next;
            ball_y    <= ball_y_next;
            ball_vy   <= ball_vy_next;
            grav_cnt  <= grav_cnt_next;
            period    <= period_next;
            step_cnt  <= step_cnt_next;
            score     <= score_next;
            game_over <= game_over_next;
            you_win   <= you_win_next;
        end
    end

    // ball registers do not move in the send states, so the record stays stable
    assign tx.valid = (state == game_pkg::SEND_LOSE) || (state == game_pkg::SEND_BALL);

    always_comb begin
        tx.data.kind      = (state == game_pkg::SEND_LOSE) ? link_pkg::kind_lose
                                                           : link_pkg::kind_ball;
        tx.data.speed_sel = 1'b1;  // returned balls always travel slow
        tx.data.gravity   = grav_cnt;
        tx.data.y         = ball_y;
        tx.data.vy        = ball_vy[7:0];
        tx.data.win       = 1'b0;
    end

endmodule

//--- source/frame_deframer.sv
`timescale 1ns/100ps

module frame_deframer (
    input  logic        clk_25MHZ,
    input  logic        reset,
    input  logic [7:0]  rx_byte,
    input  logic        rx_valid,
    output logic        rx_ready,
    ball_link_if.sender rec
);

    link_pkg::frame_t store;
    logic [1:0]       byte_cnt;
    logic             rec_valid;
    logic             take;
    logic [1:0]       first_kind;
    logic             known_kind;

    assign rx_ready = !rec_valid;  // only one frame is held at a time
    assign take     = rx_valid && rx_ready;

    // byte 0 has moved down to index 1 when the third byte arrives
    assign first_kind = store[1][1:0];
    assign known_kind = (first_kind == link_pkg::kind_ball) ||
                        (first_kind == link_pkg::kind_lose) ||
                        (first_kind == link_pkg::kind_win);

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            byte_cnt  <= 2'd0;
            rec_valid <= 1'b0;
        end else begin
            if (rec_valid && rec.ready) begin
                rec_valid <= 1'b0;
            end
            if (take) begin
                if (byte_cnt == 2'(link_pkg::frame_bytes - 1)) begin
                    byte_cnt  <= 2'd0;
                    rec_valid <= known_kind;  // unknown kinds are dropped here
                end else begin
                    byte_cnt <= byte_cnt + 2'd1;
                end
            end
        end
    end

    always_ff @(posedge clk_25MHZ) begin
        if (take) begin
            store <= {rx_byte, store[2:1]};  // new bytes enter at the top
        end
    end

    assign rec.valid = rec_valid;
    assign rec.data  = link_pkg::unpack_frame(store);  // store is frozen while rec_valid is high

endmodule

//--- source/ball_link_if.sv
`timescale 1ns/100ps

interface ball_link_if;

    link_pkg::handoff_t data;
    logic               valid;
    logic               ready;

    // data holds still from valid until the cycle where ready is also high
    modport sender (
        output data,
        output valid,
        input  ready
    );

    modport receiver (
        input  data,
        input  valid,
        output ready
    );

endinterface

//--- source/link_pkg.sv
package link_pkg;

    typedef enum logic [1:0] {
        kind_ball = 2'd0,
        kind_lose = 2'd1,
        kind_win  = 2'd2
    } frame_kind_t;                        // code 3 is not a valid frame

    localparam int frame_bytes = 3;

    typedef struct packed {
        frame_kind_t       kind;
        logic              speed_sel;      // 1 selects the slow step period
        logic [1:0]        gravity;
        logic [9:0]        y;
        logic signed [7:0] vy;
        logic              win;
    } handoff_t;

    typedef logic [2:0][7:0] frame_t;      // index 0 is the first byte on the link

    function automatic frame_t pack_frame(handoff_t r);
        frame_t f;
        f[0] = {1'b0, r.y[9:8], r.speed_sel, r.gravity, r.kind};
        f[1] = (r.kind == kind_win) ? {7'b000_0000, r.win} : r.y[7:0];
        f[2] = r.vy;
        return f;
    endfunction

    function automatic handoff_t unpack_frame(frame_t f);
        handoff_t r;
        r.kind      = frame_kind_t'(f[0][1:0]);
        r.gravity   = f[0][3:2];
        r.speed_sel = f[0][4];
        r.y         = {f[0][6:5], f[1]};
        r.vy        = f[2];
        r.win       = (r.kind == kind_win) && f[1][0];  // byte 1 carries the flag only in a win frame
        return r;
    endfunction

endpackage

//--- source/game_pkg.sv
package game_pkg;

    typedef logic [9:0] ball_coord_t;          // screen position in pixels
    typedef logic signed [9:0] ball_vel_t;     // vertical pixels per step, down is positive
    typedef logic [3:0] step_period_t;         // clock cycles between two motion steps

    localparam ball_coord_t x_step  = 10'd10;  // horizontal move per step
    localparam ball_coord_t entry_x = 10'd20;  // a received ball starts here

    localparam ball_coord_t reset_x = 10'd10;
    localparam ball_coord_t reset_y = 10'd80;

    // the far edge where an unreturned ball is lost
    localparam ball_coord_t right_limit_small = 10'd300;
    localparam ball_coord_t right_limit_large = 10'd620;

    localparam ball_coord_t y_max_small = 10'd239;  // 320x240 screen
    localparam ball_coord_t y_max_large = 10'd479;  // 640x480 screen

    localparam step_period_t step_cycles_slow = 4'd12;
    localparam step_period_t step_cycles_fast = 4'd6;

    localparam logic [9:0] return_base = 10'd12;   // divided by the paddle speed on a hit

    localparam logic [1:0] gravity_wrap = 2'd3;    // vy grows by one every fourth step

    typedef enum logic [2:0] {
        IDLE,
        RUN_RIGHT,
        RUN_LEFT,
        SEND_LOSE,
        SEND_BALL,
        AWAIT_RESULT
    } ctrl_state_t;

endpackage
